// ==== all.f ====
dram_arb_pkg.sv
client_req_if.sv
cmd_arbiter.sv
read_tag_fifo.sv
read_return_router.sv
dram_arbiter.sv
dram_mem_model.sv
dram_arb_tb.sv

// ==== client_req_if.sv ====
`timescale 1ns/100ps

// One client's command, write data and grant.
interface client_req_if;

  logic [dram_arb_pkg::ADDR_W-1:0] cmd_addr;
  logic                            cmd_rnw;
  logic                            cmd_valid;
  logic [dram_arb_pkg::DATA_W-1:0] wr_data;
  logic [dram_arb_pkg::BE_W-1:0]   wr_be;
  logic                            ack;

  // Requesting side.
  modport client (
    output cmd_addr,
    output cmd_rnw,
    output cmd_valid,
    output wr_data,
    output wr_be,
    input  ack
  );

  // Arbiter side.
  modport arb (
    input  cmd_addr,
    input  cmd_rnw,
    input  cmd_valid,
    input  wr_data,
    input  wr_be,
    output ack
  );

endinterface

// ==== cmd_arbiter.sv ====
`timescale 1ns/100ps

module cmd_arbiter (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              master_fifo_ready,
  client_req_if.arb                         c0,
  client_req_if.arb                         c1,
  output logic [dram_arb_pkg::ADDR_W-1:0]   master_cmd_addr,
  output logic                              master_cmd_rnw,
  output logic                              master_cmd_valid,
  output logic [dram_arb_pkg::DATA_W-1:0]   master_wr_data,
  output logic [dram_arb_pkg::BE_W-1:0]     master_wr_be,
  output logic                              tag_push,
  output dram_arb_pkg::client_tag_t         tag_in
);

  dram_arb_pkg::arb_state_t state;

  // Last issuer, one bit per client.
  // Only nonzero while in the wait state.
  logic [1:0] prev_arb;

  logic wr_sel_c1;

  // Grant FSM.
  // Every issue and every stall passes through the wait state.
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= dram_arb_pkg::arb0;
      prev_arb <= 2'b00;
    end else begin
      case (state)
        dram_arb_pkg::arb0: begin
          if (!master_fifo_ready || c0.cmd_valid) begin
            state    <= dram_arb_pkg::arb_wait;
            prev_arb <= {1'b0, c0.cmd_valid};
          end else if (c1.cmd_valid) begin
            // Idle grant moves to the waiting peer.
            state <= dram_arb_pkg::arb1;
          end
        end
        dram_arb_pkg::arb1: begin
          if (!master_fifo_ready || c1.cmd_valid) begin
            state    <= dram_arb_pkg::arb_wait;
            prev_arb <= {c1.cmd_valid, 1'b0};
          end else if (c0.cmd_valid) begin
            state <= dram_arb_pkg::arb0;
          end
        end
        default: begin
          // Hold here while the controller is not ready.
          if (master_fifo_ready) begin
            prev_arb <= 2'b00;
            if (c1.cmd_valid && (!c0.cmd_valid || prev_arb[0])) begin
              state <= dram_arb_pkg::arb1;
            end else begin
              state <= dram_arb_pkg::arb0;
            end
          end
        end
      endcase
    end
  end

  // Grants come straight from the one-hot bits.
  assign c0.ack = state[0];
  assign c1.ack = state[1];

  // Command path follows the grant.
  assign master_cmd_valid = (c0.ack && c0.cmd_valid) || (c1.ack && c1.cmd_valid);
  assign master_cmd_rnw   = c0.ack ? c0.cmd_rnw  : c1.cmd_rnw;
  assign master_cmd_addr  = c0.ack ? c0.cmd_addr : c1.cmd_addr;

  // Write data stays with the issuer for beat 2.
  assign wr_sel_c1      = c1.ack || prev_arb[1];
  assign master_wr_data = wr_sel_c1 ? c1.wr_data : c0.wr_data;
  assign master_wr_be   = wr_sel_c1 ? c1.wr_be   : c0.wr_be;

  // Record the owner of every read.
  assign tag_push = master_cmd_valid && master_cmd_rnw;
  assign tag_in   = c0.ack ? dram_arb_pkg::TAG_C0 : dram_arb_pkg::TAG_C1;

  a_state_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(state)
  ) else $error("grant state is not one-hot");

  // Beat 2 owns the bus in the cycle after any issue.
  a_no_back_to_back: assert property (
    @(posedge clk) disable iff (rst)
    master_cmd_valid |=> !master_cmd_valid
  ) else $error("commands issued in consecutive cycles");

endmodule

// ==== dram_arb_pkg.sv ====
package dram_arb_pkg;

  // Command address width.
  localparam int ADDR_W = 32;

  // One data beat and its byte enables.
  localparam int DATA_W = 144;
  localparam int BE_W   = 18;

  // One-hot grant state.
  // Bit 0 is the client 0 grant and bit 1 the client 1 grant, so the
  // ack levels come straight off the register.
  typedef enum logic [2:0] {
    arb0     = 3'b001,
    arb1     = 3'b010,
    arb_wait = 3'b100
  } arb_state_t;

  // Owner of an outstanding read.
  typedef logic client_tag_t;

  localparam client_tag_t TAG_C0 = 1'b1;
  localparam client_tag_t TAG_C1 = 1'b0;

endpackage

// ==== dram_arb_tb.sv ====
`timescale 1ns/100ps

module dram_arb_tb;

  // Commands over all tests, and the longest model delay in cycles.
  localparam int N_CMDS    = 96;
  localparam int MAX_DELAY = 8;
  localparam int LIMIT     = 4 * N_CMDS * MAX_DELAY;

  logic        clk;
  logic        rst;
  logic [31:0] cmd_addr [2];
  logic        cmd_rnw [2];
  logic        cmd_valid [2];
  logic [143:0] wr_data [2];
  logic [17:0] wr_be [2];
  logic [143:0] rd_data [2];
  logic        rd_valid [2];
  logic        ack_w [2];
  logic [143:0] b2_data [2];
  logic [17:0] b2_be [2];

  logic [31:0]  m_addr;
  logic         m_rnw;
  logic         m_valid;
  logic [143:0] m_wr_data;
  logic [17:0]  m_wr_be;
  logic [143:0] m_rd_data;
  logic         m_rd_valid;
  logic         m_ready;

  logic [143:0] shadow [logic [31:0]];
  logic [31:0]  wlist [2][8];
  logic [2:0]   wpos [2];
  logic         exp_owner [256];
  logic [143:0] exp_word [256];
  logic [7:0]   exp_wr_idx;
  logic [7:0]   exp_rd_idx;
  logic         rd_beat2;
  logic         b2_pending;
  logic [143:0] b2_exp_data;
  logic [17:0]  b2_exp_be;
  logic         last_issuer;
  logic         must_alt;
  logic         prev_stall;
  logic [31:0]  lfsr_state;
  int errors;
  int n_cmds;
  int n_issues;
  int stall_hits;
  int cycles;

  dram_arbiter #(.TAG_DEPTH(128)) uut (
    .clk(clk), .rst(rst),
    .master_cmd_addr(m_addr), .master_cmd_rnw(m_rnw), .master_cmd_valid(m_valid),
    .master_wr_data(m_wr_data), .master_wr_be(m_wr_be), .master_rd_data(m_rd_data),
    .master_rd_valid(m_rd_valid), .master_fifo_ready(m_ready),
    .slave0_cmd_addr(cmd_addr[0]), .slave0_cmd_rnw(cmd_rnw[0]),
    .slave0_cmd_valid(cmd_valid[0]), .slave0_wr_data(wr_data[0]), .slave0_wr_be(wr_be[0]),
    .slave0_rd_data(rd_data[0]), .slave0_rd_valid(rd_valid[0]), .slave0_ack(ack_w[0]),
    .slave1_cmd_addr(cmd_addr[1]), .slave1_cmd_rnw(cmd_rnw[1]),
    .slave1_cmd_valid(cmd_valid[1]), .slave1_wr_data(wr_data[1]), .slave1_wr_be(wr_be[1]),
    .slave1_rd_data(rd_data[1]), .slave1_rd_valid(rd_valid[1]), .slave1_ack(ack_w[1])
  );

  dram_mem_model u_mem (
    .clk(clk), .rst(rst), .cmd_addr(m_addr), .cmd_rnw(m_rnw), .cmd_valid(m_valid),
    .wr_data(m_wr_data), .rd_data(m_rd_data), .rd_valid(m_rd_valid), .fifo_ready(m_ready)
  );

  always #10 clk = ~clk;

  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [143:0] random_word();
    logic [31:0] top;
    top = take_bits(16);
    return {top[15:0], take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
  endfunction

  // Present one command, hold it until issued, then drive write beat 2.
  task automatic run_cmd(input logic c, input logic rnw, input logic [31:0] addr);
    logic done;
    logic [31:0] bits;
    cmd_addr[c]  = addr;
    cmd_rnw[c]   = rnw;
    wr_data[c]   = random_word();
    bits         = take_bits(18);
    wr_be[c]     = bits[17:0];
    b2_data[c]   = random_word();
    bits         = take_bits(18);
    b2_be[c]     = bits[17:0];
    cmd_valid[c] = 1'b1;
    n_cmds       = n_cmds + 1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = ack_w[c] && cmd_valid[c];
      @(posedge clk);
    end
    #1;
    cmd_valid[c] = 1'b0;
    wr_data[c]   = b2_data[c];
    wr_be[c]     = b2_be[c];
    if (!rnw) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_new(input logic c);
    logic [31:0] addr;
    logic [31:0] bits;
    bits = take_bits(23);
    addr = {c, bits[22:0], 8'h00};
    wlist[c][wpos[c]] = addr;
    wpos[c] = wpos[c] + 3'd1;
    run_cmd(c, 1'b0, addr);
  endtask

  // Random mix of writes and reads of earlier writes, with optional idle gaps.
  task automatic mixed_seq(input logic c, input int n, input logic gaps, input logic rd_only);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = take_bits(6);
      if (gaps) begin
        repeat (int'(r[1:0])) @(posedge clk);
        #1;
      end
      if (rd_only || r[2]) begin
        run_cmd(c, 1'b1, wlist[c][r[5:3]]);
      end else begin
        write_new(c);
      end
    end
  endtask

  task automatic drain_reads();
    while (exp_rd_idx != exp_wr_idx || rd_beat2) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic track_issue(input logic c);
    if (ack_w[c] && cmd_valid[c]) begin
      last_issuer <= c;
      must_alt <= cmd_valid[!c];
      if (!cmd_rnw[c]) begin
        shadow[cmd_addr[c]] = wr_data[c];
        b2_pending <= 1'b1;
        b2_exp_data <= b2_data[c];
        b2_exp_be <= b2_be[c];
      end else begin
        exp_owner[exp_wr_idx] = c;
        exp_word[exp_wr_idx] = shadow[cmd_addr[c]];
        exp_wr_idx <= exp_wr_idx + 8'd1;
      end
    end
  endtask

  // Reference state, taken from the client side of every issue.
  always @(posedge clk) begin
    if (rst) begin
      exp_wr_idx <= '0;
      exp_rd_idx <= '0;
      rd_beat2   <= 1'b0;
      b2_pending <= 1'b0;
      must_alt   <= 1'b0;
      prev_stall <= 1'b0;
    end else begin
      b2_pending <= 1'b0;
      prev_stall <= !m_ready;
      if (prev_stall && !m_ready) begin
        stall_hits <= stall_hits + 1;
      end
      // Issues as the controller sees them.
      if (m_valid) begin
        n_issues <= n_issues + 1;
      end
      track_issue(1'b0);
      track_issue(1'b1);
      if (m_rd_valid) begin
        rd_beat2 <= !rd_beat2;
        if (rd_beat2) begin
          exp_rd_idx <= exp_rd_idx + 8'd1;
        end
      end
    end
  end

  // Each issue reaches the controller with the client's command and beat 1.
  a_issue_c0: assert property (@(posedge clk) disable iff (rst)
    ack_w[0] && cmd_valid[0] |-> m_valid && m_addr == cmd_addr[0] && m_rnw == cmd_rnw[0]
      && m_wr_data == wr_data[0] && m_wr_be == wr_be[0]
  ) else report_error("client 0 command not forwarded to the controller");

  a_issue_c1: assert property (@(posedge clk) disable iff (rst)
    ack_w[1] && cmd_valid[1] |-> m_valid && m_addr == cmd_addr[1] && m_rnw == cmd_rnw[1]
      && m_wr_data == wr_data[1] && m_wr_be == wr_be[1]
  ) else report_error("client 1 command not forwarded to the controller");

  a_rd_owner: assert property (@(posedge clk) disable iff (rst)
    m_rd_valid |-> (rd_valid[0] != rd_valid[1]) && (rd_valid[1] == exp_owner[exp_rd_idx])
  ) else report_error("read beat steered to the wrong client");

  a_rd_data: assert property (@(posedge clk) disable iff (rst)
    m_rd_valid |-> rd_data[exp_owner[exp_rd_idx]] ==
      (rd_beat2 ? ~exp_word[exp_rd_idx] : exp_word[exp_rd_idx])
  ) else report_error("read data differs from the written word");

  a_wr_beat2: assert property (@(posedge clk) disable iff (rst)
    b2_pending |-> m_wr_data == b2_exp_data && m_wr_be == b2_exp_be
  ) else report_error("write beat 2 not from the issuing client");

  a_fair: assert property (@(posedge clk) disable iff (rst)
    m_valid && must_alt |-> ack_w[1] != last_issuer
  ) else report_error("grant did not alternate between valid clients");

  a_backpressure: assert property (@(posedge clk) disable iff (rst)
    prev_stall && !m_ready |-> !ack_w[0] && !ack_w[1] && !m_valid
  ) else report_error("command granted while controller not ready");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    lfsr_state = 32'h6a3d_cb2e;
    errors = 0;
    n_cmds = 0;
    n_issues = 0;
    stall_hits = 0;
    cycles = 0;
    for (int c = 0; c < 2; c++) begin
      cmd_addr[c] = '0;
      cmd_rnw[c] = 1'b0;
      cmd_valid[c] = 1'b0;
      wr_data[c] = '0;
      wr_be[c] = '0;
      wpos[c] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    fork
      begin
        repeat (8) write_new(1'b0);
        for (int i = 0; i < 8; i++) run_cmd(1'b0, 1'b1, wlist[0][i]);
      end
      begin
        repeat (8) write_new(1'b1);
        for (int i = 0; i < 8; i++) run_cmd(1'b1, 1'b1, wlist[1][i]);
      end
    join
    drain_reads();
    $display("test 1 write then read: done, %0d errors", errors);

    fork
      repeat (6) write_new(1'b0);
      repeat (6) write_new(1'b1);
    join
    drain_reads();
    $display("test 2 write beat 2: done, %0d errors", errors);

    fork
      mixed_seq(1'b0, 8, 1'b0, 1'b0);
      mixed_seq(1'b1, 8, 1'b0, 1'b0);
    join
    drain_reads();
    $display("test 3 fairness: done, %0d errors", errors);

    fork
      mixed_seq(1'b0, 6, 1'b1, 1'b0);
      mixed_seq(1'b1, 6, 1'b1, 1'b0);
    join
    drain_reads();
    if (n_issues != n_cmds) begin
      report_error($sformatf("%0d commands but %0d issues", n_cmds, n_issues));
    end
    if (stall_hits == 0) begin
      errors = errors + 1;
      $display("The controller never held ready low for two cycles");
    end
    $display("test 4 back-pressure: done, %0d stall cycles, %0d errors", stall_hits, errors);

    fork
      mixed_seq(1'b0, 12, 1'b1, 1'b1);
      mixed_seq(1'b1, 12, 1'b1, 1'b1);
    join
    drain_reads();
    $display("test 5 read ordering: done, %0d errors", errors);

    $display("5 tests, %0d commands, %0d issues, %0d errors", n_cmds, n_issues, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== dram_arbiter.sv ====
`timescale 1ns/100ps

module dram_arbiter #(
  parameter int TAG_DEPTH = 128
) (
  input  logic                            clk,
  input  logic                            rst,
  output logic [dram_arb_pkg::ADDR_W-1:0] master_cmd_addr,
  output logic                            master_cmd_rnw,
  output logic                            master_cmd_valid,
  output logic [dram_arb_pkg::DATA_W-1:0] master_wr_data,
  output logic [dram_arb_pkg::BE_W-1:0]   master_wr_be,
  input  logic [dram_arb_pkg::DATA_W-1:0] master_rd_data,
  input  logic                            master_rd_valid,
  input  logic                            master_fifo_ready,

  input  logic [dram_arb_pkg::ADDR_W-1:0] slave0_cmd_addr,
  input  logic                            slave0_cmd_rnw,
  input  logic                            slave0_cmd_valid,
  input  logic [dram_arb_pkg::DATA_W-1:0] slave0_wr_data,
  input  logic [dram_arb_pkg::BE_W-1:0]   slave0_wr_be,
  output logic [dram_arb_pkg::DATA_W-1:0] slave0_rd_data,
  output logic                            slave0_rd_valid,
  output logic                            slave0_ack,

  input  logic [dram_arb_pkg::ADDR_W-1:0] slave1_cmd_addr,
  input  logic                            slave1_cmd_rnw,
  input  logic                            slave1_cmd_valid,
  input  logic [dram_arb_pkg::DATA_W-1:0] slave1_wr_data,
  input  logic [dram_arb_pkg::BE_W-1:0]   slave1_wr_be,
  output logic [dram_arb_pkg::DATA_W-1:0] slave1_rd_data,
  output logic                            slave1_rd_valid,
  output logic                            slave1_ack
);

  client_req_if s0 ();
  client_req_if s1 ();

  logic                      tag_push;
  dram_arb_pkg::client_tag_t tag_in;
  dram_arb_pkg::client_tag_t tag_out;
  logic                      tag_empty;
  logic                      tag_pop;

  // Client 0 side of the request bundle.
  assign s0.cmd_addr  = slave0_cmd_addr;
  assign s0.cmd_rnw   = slave0_cmd_rnw;
  assign s0.cmd_valid = slave0_cmd_valid;
  assign s0.wr_data   = slave0_wr_data;
  assign s0.wr_be     = slave0_wr_be;
  assign slave0_ack   = s0.ack;

  // Client 1 side.
  assign s1.cmd_addr  = slave1_cmd_addr;
  assign s1.cmd_rnw   = slave1_cmd_rnw;
  assign s1.cmd_valid = slave1_cmd_valid;
  assign s1.wr_data   = slave1_wr_data;
  assign s1.wr_be     = slave1_wr_be;
  assign slave1_ack   = s1.ack;

  // Read data fans out unchanged.
  assign slave0_rd_data = master_rd_data;
  assign slave1_rd_data = master_rd_data;

  cmd_arbiter u_cmd_arbiter (
    .clk               (clk),
    .rst               (rst),
    .master_fifo_ready (master_fifo_ready),
    .c0                (s0.arb),
    .c1                (s1.arb),
    .master_cmd_addr   (master_cmd_addr),
    .master_cmd_rnw    (master_cmd_rnw),
    .master_cmd_valid  (master_cmd_valid),
    .master_wr_data    (master_wr_data),
    .master_wr_be      (master_wr_be),
    .tag_push          (tag_push),
    .tag_in            (tag_in)
  );

  read_tag_fifo #(
    .TAG_DEPTH (TAG_DEPTH)
  ) u_read_tag_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (tag_push),
    .tag_in    (tag_in),
    .pop       (tag_pop),
    .tag_out   (tag_out),
    .tag_empty (tag_empty)
  );

  read_return_router u_read_return_router (
    .clk             (clk),
    .rst             (rst),
    .master_rd_valid (master_rd_valid),
    .tag_out         (tag_out),
    .tag_empty       (tag_empty),
    .tag_pop         (tag_pop),
    .slave0_rd_valid (slave0_rd_valid),
    .slave1_rd_valid (slave1_rd_valid)
  );

endmodule

// ==== dram_mem_model.sv ====
`timescale 1ns/100ps

// Controller model with back-pressure, write storage and two-beat reads.
module dram_mem_model (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dram_arb_pkg::ADDR_W-1:0] cmd_addr,
  input  logic                            cmd_rnw,
  input  logic                            cmd_valid,
  input  logic [dram_arb_pkg::DATA_W-1:0] wr_data,
  output logic [dram_arb_pkg::DATA_W-1:0] rd_data,
  output logic                            rd_valid,
  output logic                            fifo_ready
);

  logic [dram_arb_pkg::DATA_W-1:0] store [logic [dram_arb_pkg::ADDR_W-1:0]];
  logic [dram_arb_pkg::DATA_W-1:0] pend_data [$];
  int                              pend_due [$];
  logic [dram_arb_pkg::DATA_W-1:0] cur_word;
  logic [31:0]                     lfsr_state;
  logic                            beat2;
  int                              cycle;
  int                              stall_left;

  // Galois LFSR, one step per bit.
  function automatic int draw_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  // Unwritten words still depend on every address bit.
  function automatic logic [dram_arb_pkg::DATA_W-1:0] fill(input logic [31:0] addr);
    return {addr[15:0], {4{addr}}};
  endfunction

  initial begin
    lfsr_state = 32'h6a3d_cb2e;
    rd_data    = '0;
    rd_valid   = 1'b0;
    fifo_ready = 1'b1;
    beat2      = 1'b0;
    cycle      = 0;
    stall_left = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      #1;
      rd_valid   = 1'b0;
      fifo_ready = 1'b1;
      beat2      = 1'b0;
    end else begin
      cycle = cycle + 1;
      if (cmd_valid && !cmd_rnw) begin
        store[cmd_addr] = wr_data;
      end else if (cmd_valid) begin
        pend_data.push_back(store.exists(cmd_addr) ? store[cmd_addr] : fill(cmd_addr));
        pend_due.push_back(cycle + 1 + draw_bits(3));
      end
      #1;
      // Second beat always follows the first directly.
      if (beat2) begin
        rd_data  = ~cur_word;
        rd_valid = 1'b1;
        beat2    = 1'b0;
      end else if (pend_data.size() > 0 && pend_due[0] <= cycle) begin
        cur_word = pend_data.pop_front();
        void'(pend_due.pop_front());
        rd_data  = cur_word;
        rd_valid = 1'b1;
        beat2    = 1'b1;
      end else begin
        rd_valid = 1'b0;
      end
      if (stall_left > 0) begin
        stall_left = stall_left - 1;
        fifo_ready = 1'b0;
      end else if (draw_bits(3) == 0) begin
        stall_left = draw_bits(3);
        fifo_ready = 1'b0;
      end else begin
        fifo_ready = 1'b1;
      end
    end
  end

endmodule

// ==== read_return_router.sv ====
`timescale 1ns/100ps

module read_return_router (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      master_rd_valid,
  input  dram_arb_pkg::client_tag_t tag_out,
  input  logic                      tag_empty,
  output logic                      tag_pop,
  output logic                      slave0_rd_valid,
  output logic                      slave1_rd_valid
);

  // High when the next beat starts a burst.
  logic first_beat;

  // Owner held for the second beat.
  dram_arb_pkg::client_tag_t burst_tag;
  dram_arb_pkg::client_tag_t cur_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b1;
    end else if (master_rd_valid) begin
      first_beat <= !first_beat;
    end
  end

  // The head moves on after the pop, so keep it.
  always_ff @(posedge clk) begin
    if (tag_pop) begin
      burst_tag <= tag_out;
    end
  end

  // One pop per two-beat burst.
  assign tag_pop = master_rd_valid && first_beat;

  assign cur_tag = first_beat ? tag_out : burst_tag;

  // Steer both beats to the tag owner.
  assign slave0_rd_valid = master_rd_valid && (cur_tag == dram_arb_pkg::TAG_C0);
  assign slave1_rd_valid = master_rd_valid && (cur_tag == dram_arb_pkg::TAG_C1);

  // Every returned burst needs a read issued before it.
  a_return_has_tag: assert property (
    @(posedge clk) disable iff (rst)
    (master_rd_valid && first_beat) |-> !tag_empty
  ) else $error("read return with no outstanding read");

endmodule

// ==== read_tag_fifo.sv ====
`timescale 1ns/100ps

module read_tag_fifo #(
  parameter int TAG_DEPTH = 128
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  dram_arb_pkg::client_tag_t tag_in,
  input  logic                      pop,
  output dram_arb_pkg::client_tag_t tag_out,
  output logic                      tag_empty
);

  localparam int PTR_W = $clog2(TAG_DEPTH);

  dram_arb_pkg::client_tag_t mem [TAG_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;

  // Storage.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= tag_in;
    end
  end

  // Pointers wrap on the power-of-two depth.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is visible without a pop.
  assign tag_out   = mem[rd_ptr];
  assign tag_empty = (count == '0);
  assign full      = (count == TAG_DEPTH[PTR_W:0]);

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    push |-> !full
  ) else $error("tag push while queue is full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> !tag_empty
  ) else $error("tag pop while queue is empty");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dram_arb_tb -f all.f -o sim \
  > build.log 2>&1 \
  && ./obj_dir/sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
